/* common/fastica_pkg.sv */
package fastica_pkg;

   // number of whitened channels, which is also the number of matrix rows.
   localparam int NUM_CH = 4;

   // signed fixed point used for z, w, y and g.
   typedef logic signed [25:0] sample_t;

   // full product of two samples before the fraction shift.
   typedef logic signed [51:0] product_t;

   // index of one row of the demixing matrix.
   typedef logic [1:0] row_idx_t;

   typedef enum logic [1:0] {
      IDLE,
      ISSUE,
      DRAIN
   } ctrl_state_t;

endpackage

/* common/fastica_row_if.sv */
`timescale 1ns/100ps

interface fastica_row_if
   import fastica_pkg::*;
();

   logic                     valid; // one-cycle strobe per row.
   row_idx_t                 row;
   sample_t                  val;   // y after projection, g after the cube.
   sample_t [NUM_CH-1:0]     w;     // original weights of this row.

   modport src (
      output valid,
      output row,
      output val,
      output w
   );

   modport dst (
      input valid,
      input row,
      input val,
      input w
   );

endinterface

/* fastica/fastica_ctrl.sv */
`timescale 1ns/100ps

module fastica_ctrl
   import fastica_pkg::*;
(
   input  logic     clk_fast,
   input  logic     rst_n,
   input  logic     go_fast,
   input  logic     done_row,
   output logic     fast_busy,
   output logic     load,
   output logic     issue,
   output row_idx_t issue_row
);

   ctrl_state_t state;
   row_idx_t    row_cnt;

   // operands are captured on the same edge that leaves IDLE.
   assign load = (state == IDLE) && go_fast;

   assign fast_busy = (state != IDLE); // high in every state but IDLE.

   always_ff @(posedge clk_fast or negedge rst_n) begin
      if (!rst_n) begin
         state     <= IDLE;
         row_cnt   <= '0;
         issue     <= 1'b0;
         issue_row <= '0;
      end else begin
         issue <= 1'b0;
         case (state)
            IDLE: begin
               row_cnt <= '0;
               if (go_fast) begin
                  state <= ISSUE;
               end
            end
            ISSUE: begin
               issue     <= 1'b1; // one row per cycle.
               issue_row <= row_cnt;
               row_cnt   <= row_cnt + 1'b1;
               if (row_cnt == row_idx_t'(NUM_CH - 1)) begin
                  state <= DRAIN;
               end
            end
            DRAIN: begin
               // the last row leaves the cube stage and is written on this edge.
               if (done_row) begin
                  state <= IDLE;
               end
            end
            default: begin
               state <= IDLE;
            end
         endcase
      end
   end

endmodule

/* fastica/fastica_project.sv */
`timescale 1ns/100ps

module fastica_project
   import fastica_pkg::*;
#(
   parameter int FRAC_BITS = 16
) (
   input  logic                         clk_fast,
   input  logic                         rst_n,
   input  logic                         load,
   input  logic                         issue,
   input  row_idx_t                     issue_row,
   input  sample_t [NUM_CH-1:0]         z_in,
   input  sample_t [NUM_CH*NUM_CH-1:0]  w_in,
   output sample_t [NUM_CH-1:0]         z_cap,
   fastica_row_if.src                   proj
);

   sample_t [NUM_CH-1:0]             z_r;
   sample_t [NUM_CH-1:0][NUM_CH-1:0] w_r;
   product_t [NUM_CH-1:0]            prod;
   sample_t                          y_next;

   always_ff @(posedge clk_fast) begin
      if (load) begin
         z_r <= z_in;
         for (int i = 0; i < NUM_CH; i++) begin
            for (int j = 0; j < NUM_CH; j++) begin
               w_r[i][j] <= w_in[i*NUM_CH + j];
            end
         end
      end
   end

   assign z_cap = z_r;

   always_comb begin
      y_next = '0;
      for (int j = 0; j < NUM_CH; j++) begin
         prod[j] = w_r[issue_row][j] * z_r[j];
         y_next  = y_next + sample_t'(prod[j] >>> FRAC_BITS); // each term wraps to 26 bits.
      end
   end

   always_ff @(posedge clk_fast or negedge rst_n) begin
      if (!rst_n) begin
         proj.valid <= 1'b0;
      end else begin
         proj.valid <= issue;
      end
   end

   always_ff @(posedge clk_fast) begin
      proj.row <= issue_row;
      proj.val <= y_next;
      proj.w   <= w_r[issue_row];
   end

endmodule

/* fastica/fastica_cube.sv */
`timescale 1ns/100ps

module fastica_cube
   import fastica_pkg::*;
#(
   parameter int FRAC_BITS = 16
) (
   input logic        clk_fast,
   input logic        rst_n,
   fastica_row_if.dst proj,
   fastica_row_if.src cube
);

   logic                 sq_valid;
   row_idx_t             sq_row;
   sample_t              sq_val;
   sample_t              sq_y;  // y is needed again for the second multiply.
   sample_t [NUM_CH-1:0] sq_w;
   product_t             sq_prod;
   product_t             cu_prod;

   assign sq_prod = proj.val * proj.val;
   assign cu_prod = sq_val * sq_y;

   always_ff @(posedge clk_fast or negedge rst_n) begin
      if (!rst_n) begin
         sq_valid   <= 1'b0;
         cube.valid <= 1'b0;
      end else begin
         sq_valid   <= proj.valid;
         cube.valid <= sq_valid;
      end
   end

   always_ff @(posedge clk_fast) begin
      sq_row   <= proj.row;
      sq_val   <= sample_t'(sq_prod >>> FRAC_BITS);
      sq_y     <= proj.val;
      sq_w     <= proj.w;
      cube.row <= sq_row;
      cube.val <= sample_t'(cu_prod >>> FRAC_BITS); // g is y cubed.
      cube.w   <= sq_w;
   end

endmodule

/* fastica/fastica_update.sv */
`timescale 1ns/100ps

module fastica_update
   import fastica_pkg::*;
#(
   parameter int FRAC_BITS = 16
) (
   input  logic                        clk_fast,
   input  logic                        rst_n,
   fastica_row_if.dst                  cube,
   input  sample_t [NUM_CH-1:0]        z_cap,
   output sample_t [NUM_CH*NUM_CH-1:0] w_out
);

   localparam sample_t KURT_GAIN = 26'sd3; // derivative term of the kurtosis contrast.

   product_t [NUM_CH-1:0] zg_prod;
   sample_t  [NUM_CH-1:0] zg;
   sample_t  [NUM_CH-1:0] w_scaled;
   sample_t  [NUM_CH-1:0] new_row;

   always_comb begin
      for (int j = 0; j < NUM_CH; j++) begin
         zg_prod[j]  = z_cap[j] * cube.val;
         zg[j]       = sample_t'(zg_prod[j] >>> FRAC_BITS);
         w_scaled[j] = KURT_GAIN * cube.w[j]; // wraps like every other result.
         new_row[j]  = zg[j] - w_scaled[j];
      end
   end

   always_ff @(posedge clk_fast or negedge rst_n) begin
      if (!rst_n) begin
         w_out <= '0;
      end else if (cube.valid) begin
         for (int j = 0; j < NUM_CH; j++) begin
            w_out[cube.row*NUM_CH + j] <= new_row[j];
         end
      end
   end

endmodule

/* rtl/fastica_top.sv */
`timescale 1ns/100ps

module fastica_top
   import fastica_pkg::*;
#(
   parameter int FRAC_BITS = 16
) (
   input  logic    clk_fast,
   input  logic    rst_n,
   input  logic    go_fast,
   input  sample_t z1, z2, z3, z4,
   input  sample_t w11_in, w12_in, w13_in, w14_in,
   input  sample_t w21_in, w22_in, w23_in, w24_in,
   input  sample_t w31_in, w32_in, w33_in, w34_in,
   input  sample_t w41_in, w42_in, w43_in, w44_in,
   output logic    fast_busy,
   output sample_t w11_out, w12_out, w13_out, w14_out,
   output sample_t w21_out, w22_out, w23_out, w24_out,
   output sample_t w31_out, w32_out, w33_out, w34_out,
   output sample_t w41_out, w42_out, w43_out, w44_out
);

   logic                        load;
   logic                        issue;
   row_idx_t                    issue_row;
   logic                        done_row;
   sample_t [NUM_CH-1:0]        z_in;
   sample_t [NUM_CH-1:0]        z_cap;
   sample_t [NUM_CH*NUM_CH-1:0] w_in;
   sample_t [NUM_CH*NUM_CH-1:0] w_out;

   fastica_row_if proj_if ();
   fastica_row_if cube_if ();

   // element 0 is z1 and w11, row major.
   assign z_in = {z4, z3, z2, z1};
   assign w_in = {w44_in, w43_in, w42_in, w41_in, w34_in, w33_in, w32_in, w31_in,
                  w24_in, w23_in, w22_in, w21_in, w14_in, w13_in, w12_in, w11_in};

   assign {w44_out, w43_out, w42_out, w41_out, w34_out, w33_out, w32_out, w31_out,
           w24_out, w23_out, w22_out, w21_out, w14_out, w13_out, w12_out, w11_out} = w_out;

   assign done_row = cube_if.valid && (cube_if.row == row_idx_t'(NUM_CH - 1));

   fastica_ctrl fastica_ctrl_inst (
      .clk_fast  (clk_fast),
      .rst_n     (rst_n),
      .go_fast   (go_fast),
      .done_row  (done_row),
      .fast_busy (fast_busy),
      .load      (load),
      .issue     (issue),
      .issue_row (issue_row)
   );

   fastica_project #(.FRAC_BITS(FRAC_BITS)) fastica_project_inst (
      .clk_fast  (clk_fast),
      .rst_n     (rst_n),
      .load      (load),
      .issue     (issue),
      .issue_row (issue_row),
      .z_in      (z_in),
      .w_in      (w_in),
      .z_cap     (z_cap),
      .proj      (proj_if.src)
   );

   fastica_cube #(.FRAC_BITS(FRAC_BITS)) fastica_cube_inst (
      .clk_fast (clk_fast),
      .rst_n    (rst_n),
      .proj     (proj_if.dst),
      .cube     (cube_if.src)
   );

   fastica_update #(.FRAC_BITS(FRAC_BITS)) fastica_update_inst (
      .clk_fast (clk_fast),
      .rst_n    (rst_n),
      .cube     (cube_if.dst),
      .z_cap    (z_cap),
      .w_out    (w_out)
   );

endmodule

/* tb/fastica_ref_model.svh */
`ifndef FASTICA_REF_MODEL_SVH
`define FASTICA_REF_MODEL_SVH

localparam longint MODEL_GAIN = 3; // kurtosis gain of the update rule.

// signed product, arithmetic shift by the fraction bits, low 26 bits kept.
function automatic sample_t fx_mul(input sample_t a, input sample_t b, input int frac);
   longint p;
   p = longint'(a) * longint'(b);
   return sample_t'(p >>> frac);
endfunction

function automatic void expected_update(
   input  sample_t z     [NUM_CH],
   input  sample_t w     [NUM_CH*NUM_CH],
   input  int      frac,
   output sample_t w_new [NUM_CH*NUM_CH]
);
   longint  acc;
   longint  zg;
   sample_t y;
   sample_t g;
   for (int i = 0; i < NUM_CH; i++) begin
      acc = 0;
      for (int j = 0; j < NUM_CH; j++) begin
         acc = acc + longint'(fx_mul(w[i*NUM_CH + j], z[j], frac));
      end
      y = sample_t'(acc);                       // the projection wraps as well.
      g = fx_mul(fx_mul(y, y, frac), y, frac);  // g is y cubed.
      for (int j = 0; j < NUM_CH; j++) begin
         zg                  = longint'(fx_mul(z[j], g, frac));
         w_new[i*NUM_CH + j] = sample_t'(zg - MODEL_GAIN * longint'(w[i*NUM_CH + j]));
      end
   end
endfunction

`endif

/* tb/tb_fastica_top.sv */
`timescale 1ns/100ps

module tb_fastica_top
   import fastica_pkg::*;
();

   localparam int FRAC_BITS      = 16;
   localparam int NUM_EL         = NUM_CH * NUM_CH;
   localparam int NUM_DIRECTED   = 5;
   localparam int NUM_RANDOM     = 8;
   localparam int NUM_ENTRIES    = NUM_DIRECTED + NUM_RANDOM;
   localparam int RUN_CYCLES     = 8;
   localparam int TIMEOUT_CYCLES = 40 * NUM_ENTRIES + 100;

   logic        clk_fast = 1'b0;
   logic        rst_n;
   logic        go_fast;
   logic        fast_busy;
   sample_t     z_drv     [NUM_CH];
   sample_t     w_drv     [NUM_EL];
   sample_t     w_out_arr [NUM_EL];
   sample_t     zero_mat  [NUM_EL];
   sample_t     z_tab     [NUM_ENTRIES][NUM_CH];
   sample_t     w_tab     [NUM_ENTRIES][NUM_EL];
   bit          hold_tab  [NUM_ENTRIES];
   int          value_errors  = 0;
   int          timing_errors = 0;
   int          cycle_count   = 0;
   logic [31:0] rng_state     = 32'd90035;

   `include "fastica_ref_model.svh"

   always #4 clk_fast = ~clk_fast;

   fastica_top #(.FRAC_BITS(FRAC_BITS)) fastica_top_inst (
      .clk_fast (clk_fast), .rst_n (rst_n), .go_fast (go_fast), .fast_busy (fast_busy),
      .z1 (z_drv[0]), .z2 (z_drv[1]), .z3 (z_drv[2]), .z4 (z_drv[3]),
      .w11_in (w_drv[0]),  .w12_in (w_drv[1]),  .w13_in (w_drv[2]),  .w14_in (w_drv[3]),
      .w21_in (w_drv[4]),  .w22_in (w_drv[5]),  .w23_in (w_drv[6]),  .w24_in (w_drv[7]),
      .w31_in (w_drv[8]),  .w32_in (w_drv[9]),  .w33_in (w_drv[10]), .w34_in (w_drv[11]),
      .w41_in (w_drv[12]), .w42_in (w_drv[13]), .w43_in (w_drv[14]), .w44_in (w_drv[15]),
      .w11_out (w_out_arr[0]),  .w12_out (w_out_arr[1]),  .w13_out (w_out_arr[2]),
      .w14_out (w_out_arr[3]),  .w21_out (w_out_arr[4]),  .w22_out (w_out_arr[5]),
      .w23_out (w_out_arr[6]),  .w24_out (w_out_arr[7]),  .w31_out (w_out_arr[8]),
      .w32_out (w_out_arr[9]),  .w33_out (w_out_arr[10]), .w34_out (w_out_arr[11]),
      .w41_out (w_out_arr[12]), .w42_out (w_out_arr[13]), .w43_out (w_out_arr[14]),
      .w44_out (w_out_arr[15])
   );

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // magnitude stays below 2.0 in fixed point.
   function automatic sample_t next_rand_sample();
      rng_state = xorshift32(rng_state);
      return sample_t'(int'(rng_state % 32'd262143) - 131071);
   endfunction

   task automatic build_table();
      for (int e = 0; e < NUM_ENTRIES; e++) begin
         hold_tab[e] = (e % 2 == 0);
         for (int j = 0; j < NUM_CH; j++) begin
            z_tab[e][j] = (e < NUM_DIRECTED) ? sample_t'(0) : next_rand_sample();
         end
         for (int k = 0; k < NUM_EL; k++) begin
            w_tab[e][k] = (e < NUM_DIRECTED) ? sample_t'(0) : next_rand_sample();
         end
      end
      z_tab[0] = '{26'sd98304, -26'sd32768, 26'sd16384, 26'sd131072};
      for (int i = 0; i < NUM_CH; i++) begin
         w_tab[0][i*NUM_CH + i] = 26'sd65536; // identity matrix.
      end
      for (int j = 0; j < NUM_CH; j++) begin
         z_tab[2][j] = sample_t'(-8200 + j * 5466);
         z_tab[4][j] = 26'sd1000000;           // y cubed overflows 26 bits here.
      end
      for (int k = 0; k < NUM_EL; k++) begin
         w_tab[2][k] = sample_t'(-8200 + k * 1093);
         w_tab[3][k] = sample_t'(-(k + 1) * 4096);
         w_tab[4][k] = 26'sd65536;
      end
      z_tab[3] = '{26'sd65536, 26'sd32768, -26'sd49152, 26'sd16384};
   endtask

   task automatic check_matrix(input sample_t exp_mat [NUM_EL], input string what);
      for (int k = 0; k < NUM_EL; k++) begin
         assert (w_out_arr[k] === exp_mat[k]) else begin
            $display("ERROR at %0t ns: %s, w%0d%0d_out expected %0d, got %0d", $time, what,
                     k / NUM_CH + 1, k % NUM_CH + 1, exp_mat[k], w_out_arr[k]);
            value_errors++;
         end
      end
   endtask

   task automatic check_busy(input logic exp_busy, input string what);
      assert (fast_busy === exp_busy) else begin
         $display("ERROR at %0t ns: %s, fast_busy expected %0b, got %0b", $time, what,
                  exp_busy, fast_busy);
         timing_errors++;
      end
   endtask

   task automatic scramble_inputs();
      for (int j = 0; j < NUM_CH; j++) begin
         z_drv[j] = ~z_drv[j];
      end
      for (int k = 0; k < NUM_EL; k++) begin
         w_drv[k] = ~w_drv[k];
      end
   endtask

   task automatic run_entry(input int e);
      sample_t exp_mat [NUM_EL];
      int      runs;
      int      busy_cycles;
      for (int j = 0; j < NUM_CH; j++) begin
         z_drv[j] = z_tab[e][j];
      end
      for (int k = 0; k < NUM_EL; k++) begin
         w_drv[k] = w_tab[e][k];
      end
      expected_update(z_tab[e], w_tab[e], FRAC_BITS, exp_mat);
      runs = hold_tab[e] ? 2 : 1;
      check_busy(1'b0, "idle before go_fast");
      go_fast = 1'b1;
      for (int r = 0; r < runs; r++) begin
         @(negedge clk_fast);
         check_busy(1'b1, "start of run"); // low for only one cycle between held runs.
         if (r == runs - 1) begin
            go_fast = 1'b0;
            scramble_inputs();
         end
         busy_cycles = 0;
         while (fast_busy === 1'b1) begin
            busy_cycles++;
            @(negedge clk_fast);
         end
         assert (busy_cycles == RUN_CYCLES) else begin
            $display("ERROR at %0t ns: entry %0d, fast_busy high for %0d cycles, expected %0d",
                     $time, e, busy_cycles, RUN_CYCLES);
            timing_errors++;
         end
         check_matrix(exp_mat, $sformatf("entry %0d run %0d", e, r));
      end
      for (int j = 0; j < NUM_CH; j++) begin
         z_drv[j] = next_rand_sample();
      end
      for (int k = 0; k < NUM_EL; k++) begin
         w_drv[k] = next_rand_sample();
      end
      repeat (3) begin
         @(negedge clk_fast);
         check_busy(1'b0, "idle between runs");
         check_matrix(exp_mat, $sformatf("entry %0d hold", e));
      end
   endtask

   always @(posedge clk_fast) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("simulation timed out after %0d cycles before all tests finished",
                  cycle_count);
         $display("Test failures found");
         $finish;
      end
   end

   initial begin
      rst_n   = 1'b0;
      go_fast = 1'b0;
      for (int k = 0; k < NUM_EL; k++) begin
         w_drv[k]    = '0;
         zero_mat[k] = '0;
      end
      for (int j = 0; j < NUM_CH; j++) begin
         z_drv[j] = '0;
      end
      build_table();
      repeat (5) begin
         @(negedge clk_fast);
         check_busy(1'b0, "during reset");
         check_matrix(zero_mat, "during reset");
      end
      rst_n = 1'b1;
      repeat (2) begin
         @(negedge clk_fast);
         check_busy(1'b0, "after reset");
         check_matrix(zero_mat, "after reset");
      end
      for (int e = 0; e < NUM_ENTRIES; e++) begin
         run_entry(e);
      end
      $display("summary: %0d value errors, %0d timing errors", value_errors, timing_errors);
      if (value_errors + timing_errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

/* filelist.f */
+incdir+tb
common/fastica_pkg.sv
common/fastica_row_if.sv
fastica/fastica_ctrl.sv
fastica/fastica_project.sv
fastica/fastica_cube.sv
fastica/fastica_update.sv
rtl/fastica_top.sv
tb/tb_fastica_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_fastica_top
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
PASS_MSG  ?= All tests passed!

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -q -F '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
